// File: src/idctPkg.sv
// Shared types, cosine coefficients and schedule constants
// for the IDCT row pass
`default_nettype none

package idctPkg;

    // ----------------------------------------
    // Data widths
    // ----------------------------------------
    typedef logic signed [15:0] sampleT;   // Input sample or coefficient
    typedef logic signed [31:0] accT;      // Product or butterfly sum
    typedef logic signed [42:0] rotT;      // Rotation product
    typedef accT [7:0] accVecT;            // One register bank

    typedef logic [2:0] pageT;             // Row within the block
    typedef logic [2:0] slotT;             // Position in a page schedule
    typedef logic [4:0] addrT;             // {page, slot[1:0]}

    // Control word travelling with the data
    typedef struct packed {
        logic valid;
        pageT page;
        slotT slot;
    } ctrlT;

    typedef enum logic {
        fetchIdle,
        fetchBusy
    } fetchStateT;

    // ----------------------------------------
    // cos(k*pi/16) scaled by 4096
    // ----------------------------------------
    localparam sampleT coefC1 = 16'sd4017;
    localparam sampleT coefC2 = 16'sd3784;
    localparam sampleT coefC3 = 16'sd3406;
    localparam sampleT coefC4 = 16'sd2896;
    localparam sampleT coefC5 = 16'sd2276;
    localparam sampleT coefC6 = 16'sd1567;
    localparam sampleT coefC7 = 16'sd799;

    localparam sampleT coefRot  = 16'sd181;  // cos(pi/4) * 256
    localparam int     rotShift = 8;

    // Schedule
    localparam int slotsPerPage  = 7;        // Slots 4..6 leave the banks time to settle
    localparam int readSlots     = 4;
    localparam int pagesPerBlock = 8;

endpackage

`default_nettype wire

// File: src/idctFetchSeq.sv
// Page/slot sequencer: read strobe, read address and the control word
`timescale 1ns/1ps
`default_nettype none

module idctFetchSeq
    import idctPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic dataInEnable,
    output logic dataInRead,
    output addrT dataInAddress,
    output ctrlT ctrl
);

    fetchStateT state;
    pageT       page;
    slotT       slot;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= fetchIdle;
            page  <= '0;
            slot  <= '0;
        end else begin
            case (state)
                fetchIdle: begin
                    if (dataInEnable) begin   // Start only honoured here
                        state <= fetchBusy;
                        page  <= '0;
                        slot  <= '0;
                    end
                end
                fetchBusy: begin
                    if (slot == slotT'(slotsPerPage - 1)) begin
                        slot <= '0;
                        if (page == pageT'(pagesPerBlock - 1)) begin
                            state <= fetchIdle;  // Block done
                            page  <= '0;
                        end else begin
                            page <= page + 3'd1;
                        end
                    end else begin
                        slot <= slot + 3'd1;
                    end
                end
                default: state <= fetchIdle;
            endcase
        end
    end

    // Lines up with the read data from the memory
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ctrl <= '0;
        end else begin
            ctrl <= '{valid: (state == fetchBusy), page: page, slot: slot};
        end
    end

    assign dataInRead    = (state == fetchBusy) && (slot < slotT'(readSlots));
    assign dataInAddress = {page, slot[1:0]};

endmodule

`default_nettype wire

// File: src/idctCoefMult.sv
// Coefficient selection per slot and the four registered multipliers
`timescale 1ns/1ps
`default_nettype none

module idctCoefMult
    import idctPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  ctrlT   ctrl,
    input  sampleT dataInA,
    input  sampleT dataInB,
    output accT    prodA0,
    output accT    prodB0,
    output accT    prodA1,
    output accT    prodB1
);

    // First and fourth coefficient always match, as do second and third
    sampleT coefOuter;
    sampleT coefInner;

    always_comb begin
        case (ctrl.slot)
            3'd0: begin
                coefOuter = coefC4;
                coefInner = coefC4;
            end
            3'd1: begin
                coefOuter = coefC2;
                coefInner = coefC6;
            end
            3'd2: begin
                coefOuter = coefC1;
                coefInner = coefC7;
            end
            3'd3: begin
                coefOuter = coefC5;
                coefInner = coefC3;
            end
            default: begin       // Gap slots
                coefOuter = '0;
                coefInner = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prodA0 <= '0;
            prodB0 <= '0;
            prodA1 <= '0;
            prodB1 <= '0;
        end else begin
            prodA0 <= accT'(dataInA) * accT'(coefOuter);
            prodB0 <= accT'(dataInB) * accT'(coefInner);
            prodA1 <= accT'(dataInA) * accT'(coefInner);
            prodB1 <= accT'(dataInB) * accT'(coefOuter);
        end
    end

endmodule

`default_nettype wire

// File: src/idctEvenOddStage.sv
// First butterfly: sum and difference of the products, scattered
// into the s-bank by slot
`timescale 1ns/1ps
`default_nettype none

module idctEvenOddStage
    import idctPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  ctrlT   ctrlIn,
    input  accT    prodA0,
    input  accT    prodB0,
    input  accT    prodA1,
    input  accT    prodB1,
    output ctrlT   ctrlOut,
    output accVecT sBank
);

    ctrlT ctrlD;   // Aligned with the products
    accT  sumAB;
    accT  diffAB;

    assign sumAB  = prodA0 + prodB0;
    assign diffAB = prodA1 - prodB1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ctrlD   <= '0;
            ctrlOut <= '0;
            sBank   <= '0;
        end else begin
            ctrlD   <= ctrlIn;
            ctrlOut <= ctrlD;
            if (ctrlD.valid) begin
                case (ctrlD.slot)
                    3'd0: begin sBank[0] <= sumAB; sBank[1] <= diffAB; end
                    3'd1: begin sBank[3] <= sumAB; sBank[2] <= diffAB; end
                    3'd2: begin sBank[7] <= sumAB; sBank[4] <= diffAB; end
                    3'd3: begin sBank[6] <= sumAB; sBank[5] <= diffAB; end
                    default: ;   // Gap, bank holds
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: src/idctButterflyStage.sv
// Second butterfly: pairs gathered from the s-bank, sums and
// differences written to the t-bank
`timescale 1ns/1ps
`default_nettype none

module idctButterflyStage
    import idctPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  ctrlT   ctrlIn,
    input  accVecT sBank,
    output ctrlT   ctrlOut,
    output accVecT tBank
);

    ctrlT ctrlD;
    accT  pairHi;
    accT  pairLo;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ctrlD   <= '0;
            ctrlOut <= '0;
        end else begin
            ctrlD   <= ctrlIn;
            ctrlOut <= ctrlD;
        end
    end

    // s-bank pair for this slot
    always_comb begin
        case (ctrlD.slot)
            3'd0: begin pairHi = sBank[0]; pairLo = sBank[3]; end
            3'd1: begin pairHi = sBank[1]; pairLo = sBank[2]; end
            3'd2: begin pairHi = sBank[4]; pairLo = sBank[5]; end
            3'd3: begin pairHi = sBank[7]; pairLo = sBank[6]; end
            default: begin
                pairHi = '0;
                pairLo = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrlD.valid) begin
            case (ctrlD.slot)
                3'd0: begin
                    tBank[0] <= pairHi + pairLo;
                    tBank[3] <= pairHi - pairLo;
                end
                3'd1: begin
                    tBank[1] <= pairHi + pairLo;
                    tBank[2] <= pairHi - pairLo;
                end
                3'd2: begin
                    tBank[4] <= pairHi + pairLo;
                    tBank[5] <= pairHi - pairLo;
                end
                3'd3: begin
                    tBank[7] <= pairHi + pairLo;
                    tBank[6] <= pairHi - pairLo;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/idctOutputStage.sv
// pi/4 rotation of t5/t6 and the final add/subtract stage
// producing the tagged output pairs
`timescale 1ns/1ps
`default_nettype none

module idctOutputStage
    import idctPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  ctrlT   ctrlIn,
    input  accVecT tBank,
    output logic   dataOutEnable,
    output pageT   dataOutPage,
    output logic [1:0] dataOutCount,
    output accT    data0Out,
    output accT    data1Out
);

    ctrlT ctrlD1;  // Rotation
    ctrlT ctrlD2;
    ctrlT ctrlD3;  // Pair selection
    ctrlT ctrlD4;  // Output register

    accT t5;
    accT t6;
    rotT rotSum;
    rotT rotDiff;
    rotT rotA;
    rotT rotB;
    accT rotU;
    accT rotV;
    accT selHi;
    accT selLo;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ctrlD1 <= '0;
            ctrlD2 <= '0;
            ctrlD3 <= '0;
            ctrlD4 <= '0;
        end else begin
            ctrlD1 <= ctrlIn;
            ctrlD2 <= ctrlD1;
            ctrlD3 <= ctrlD2;
            ctrlD4 <= ctrlD3;
        end
    end

    // ----------------------------------------
    // Rotation, needs t6 from slot 3
    // ----------------------------------------
    assign t5      = tBank[5];
    assign t6      = tBank[6];
    assign rotSum  = rotT'(t6) + rotT'(t5);
    assign rotDiff = rotT'(t6) - rotT'(t5);

    always_ff @(posedge clk) begin
        if (ctrlD1.valid && ctrlD1.slot == 3'd2) begin
            rotA <= rotSum * rotT'(coefRot);
            rotB <= rotDiff * rotT'(coefRot);
        end
    end

    assign rotU = accT'(rotA >>> rotShift);
    assign rotV = accT'(rotB >>> rotShift);

    // ----------------------------------------
    // Final add/subtract
    // ----------------------------------------
    always_comb begin
        case (ctrlD3.slot)
            3'd0: begin selHi = tBank[0]; selLo = tBank[7]; end
            3'd1: begin selHi = tBank[1]; selLo = rotU;     end
            3'd2: begin selHi = tBank[2]; selLo = rotV;     end
            3'd3: begin selHi = tBank[3]; selLo = tBank[4]; end
            default: begin
                selHi = '0;
                selLo = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        data0Out <= selHi + selLo;
        data1Out <= selHi - selLo;
    end

    assign dataOutEnable = ctrlD4.valid && (ctrlD4.slot < slotT'(readSlots));
    assign dataOutPage   = ctrlD4.page;
    assign dataOutCount  = ctrlD4.slot[1:0];

endmodule

`default_nettype wire

// File: src/idctRow.sv
// Row-pass IDCT core: sequencer, coefficient multiply and the
// three butterfly/output stages
`timescale 1ns/1ps
`default_nettype none

module idctRow
    import idctPkg::*;
(
    input  logic   clk,
    input  logic   rst,

    input  logic   dataInEnable,
    output logic   dataInRead,
    output addrT   dataInAddress,
    input  sampleT dataInA,
    input  sampleT dataInB,

    output logic   dataOutEnable,
    output pageT   dataOutPage,
    output logic [1:0] dataOutCount,
    output accT    data0Out,
    output accT    data1Out
);

    ctrlT   fetchCtrl;   // Aligned with read data
    ctrlT   evenOddCtrl;
    ctrlT   butterflyCtrl;
    accT    prodA0;
    accT    prodB0;
    accT    prodA1;
    accT    prodB1;
    accVecT sBank;
    accVecT tBank;

    idctFetchSeq fetch0 (
        .clk           (clk),
        .rst           (rst),
        .dataInEnable  (dataInEnable),
        .dataInRead    (dataInRead),
        .dataInAddress (dataInAddress),
        .ctrl          (fetchCtrl)
    );

    idctCoefMult mult0 (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (fetchCtrl),
        .dataInA (dataInA),
        .dataInB (dataInB),
        .prodA0  (prodA0),
        .prodB0  (prodB0),
        .prodA1  (prodA1),
        .prodB1  (prodB1)
    );

    idctEvenOddStage evenOdd0 (
        .clk     (clk),
        .rst     (rst),
        .ctrlIn  (fetchCtrl),
        .prodA0  (prodA0),
        .prodB0  (prodB0),
        .prodA1  (prodA1),
        .prodB1  (prodB1),
        .ctrlOut (evenOddCtrl),
        .sBank   (sBank)
    );

    idctButterflyStage butterfly0 (
        .clk     (clk),
        .rst     (rst),
        .ctrlIn  (evenOddCtrl),
        .sBank   (sBank),
        .ctrlOut (butterflyCtrl),
        .tBank   (tBank)
    );

    idctOutputStage out0 (
        .clk           (clk),
        .rst           (rst),
        .ctrlIn        (butterflyCtrl),
        .tBank         (tBank),
        .dataOutEnable (dataOutEnable),
        .dataOutPage   (dataOutPage),
        .dataOutCount  (dataOutCount),
        .data0Out      (data0Out),
        .data1Out      (data1Out)
    );

endmodule

`default_nettype wire

// File: test/idctRow_props.sv
// Bound checks on the read schedule, read-to-output latency, output tags
// and the number of outputs per block
`timescale 1ns/1ps
`default_nettype none

module idctRowProps
    import idctPkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       dataInEnable,
    input logic       dataInRead,
    input addrT       dataInAddress,
    input logic       dataOutEnable,
    input pageT       dataOutPage,
    input logic [1:0] dataOutCount
);

    logic       expBusy;      // Expected sequencer activity
    logic [5:0] expCycle;     // Cycle within the block, 0..55
    pageT       expPage;
    slotT       expSlot;
    int         outsInBlock;

    // Failure counts, one per assertion
    int schedFails = 0;
    int addrFails = 0;
    int latencyFails = 0;
    int tagFails = 0;
    int countFails = 0;

    assign expPage = pageT'(expCycle / 6'(slotsPerPage));
    assign expSlot = slotT'(expCycle % 6'(slotsPerPage));

    // ----------------------------------------
    // Block schedule, start ignored while busy
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            expBusy  <= 1'b0;
            expCycle <= '0;
        end else if (!expBusy) begin
            if (dataInEnable) begin
                expBusy  <= 1'b1;
                expCycle <= '0;
            end
        end else if (expCycle == 6'(slotsPerPage * pagesPerBlock - 1)) begin
            expBusy <= 1'b0;
        end else begin
            expCycle <= expCycle + 6'd1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            outsInBlock <= 0;
        end else if (dataOutEnable) begin
            outsInBlock <= (dataOutPage == '0 && dataOutCount == '0) ? 1 : outsInBlock + 1;
        end
    end

    schedRead: assert property (@(posedge clk) disable iff (!rst)
        dataInRead == (expBusy && expSlot < slotT'(readSlots)))
        else begin
            schedFails++;
            $error("ERR %0t: read strobe off the page schedule", $time);
        end

    readAddr: assert property (@(posedge clk) disable iff (!rst)
        dataInRead |-> dataInAddress == {expPage, expSlot[1:0]})
        else begin
            addrFails++;
            $error("ERR %0t: read address %0h out of order", $time, dataInAddress);
        end

    // Outputs appear 9 cycles after the read and never otherwise
    outLatency: assert property (@(posedge clk) disable iff (!rst)
        dataOutEnable == $past(dataInRead, 9))
        else begin
            latencyFails++;
            $error("ERR %0t: output strobe not 9 cycles after a read", $time);
        end

    outTag: assert property (@(posedge clk) disable iff (!rst)
        dataOutEnable |-> {dataOutPage, dataOutCount} == $past(dataInAddress, 9))
        else begin
            tagFails++;
            $error("ERR %0t: output tag does not match its read address", $time);
        end

    outCount: assert property (@(posedge clk) disable iff (!rst)
        (dataOutEnable && dataOutPage == 3'd7 && dataOutCount == 2'd3)
            |-> outsInBlock == readSlots * pagesPerBlock - 1)
        else begin
            countFails++;
            $error("ERR %0t: block ended after %0d outputs", $time, outsInBlock + 1);
        end

endmodule

bind idctRow idctRowProps props0 (
    .clk           (clk),
    .rst           (rst),
    .dataInEnable  (dataInEnable),
    .dataInRead    (dataInRead),
    .dataInAddress (dataInAddress),
    .dataOutEnable (dataOutEnable),
    .dataOutPage   (dataOutPage),
    .dataOutCount  (dataOutCount)
);

`default_nettype wire

// File: test/idctRowTb.sv
// Testbench for the IDCT row core: clock, reset, sample memory,
// reference model, output checks and the final verdict
`timescale 1ns/1ps
`default_nettype none

module idctRowTb
    import idctPkg::*;
();

    typedef struct packed {
        sampleT a;
        sampleT b;
    } pairT;

    typedef struct packed {
        accT d0;
        accT d1;
    } outPairT;

    logic       clk;
    logic       rst;
    logic       dataInEnable;
    logic       dataInRead;
    addrT       dataInAddress;
    sampleT     dataInA;
    sampleT     dataInB;
    logic       dataOutEnable;
    pageT       dataOutPage;
    logic [1:0] dataOutCount;
    accT        data0Out;
    accT        data1Out;

    pairT    mem [32];          // {page, pair} addressed sample pairs
    integer  seed = 32'h4684_79eb;
    logic    readPending;
    addrT    readAddr;
    outPairT expOut;
    int      outputsSeen = 0;
    int      dataErrors = 0;

    idctRow dut0 (
        .clk           (clk),
        .rst           (rst),
        .dataInEnable  (dataInEnable),
        .dataInRead    (dataInRead),
        .dataInAddress (dataInAddress),
        .dataInA       (dataInA),
        .dataInB       (dataInB),
        .dataOutEnable (dataOutEnable),
        .dataOutPage   (dataOutPage),
        .dataOutCount  (dataOutCount),
        .data0Out      (data0Out),
        .data1Out      (data1Out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    // ----------------------------------------
    // Reference model of one row
    // ----------------------------------------
    function automatic outPairT refOutput(input pageT p, input logic [1:0] c);
        accT     x [8];
        accT     s [8];
        accT     t [8];
        accT     u;
        accT     v;
        outPairT r;
        x[0] = accT'(mem[{p, 2'd0}].a);
        x[4] = accT'(mem[{p, 2'd0}].b);
        x[2] = accT'(mem[{p, 2'd1}].a);
        x[6] = accT'(mem[{p, 2'd1}].b);
        x[1] = accT'(mem[{p, 2'd2}].a);
        x[7] = accT'(mem[{p, 2'd2}].b);
        x[5] = accT'(mem[{p, 2'd3}].a);
        x[3] = accT'(mem[{p, 2'd3}].b);
        s[0] = x[0] * accT'(coefC4) + x[4] * accT'(coefC4);
        s[1] = x[0] * accT'(coefC4) - x[4] * accT'(coefC4);
        s[3] = x[2] * accT'(coefC2) + x[6] * accT'(coefC6);
        s[2] = x[2] * accT'(coefC6) - x[6] * accT'(coefC2);
        s[7] = x[1] * accT'(coefC1) + x[7] * accT'(coefC7);
        s[4] = x[1] * accT'(coefC7) - x[7] * accT'(coefC1);
        s[6] = x[5] * accT'(coefC5) + x[3] * accT'(coefC3);
        s[5] = x[5] * accT'(coefC3) - x[3] * accT'(coefC5);
        t[0] = s[0] + s[3];
        t[3] = s[0] - s[3];
        t[1] = s[1] + s[2];
        t[2] = s[1] - s[2];
        t[4] = s[4] + s[5];
        t[5] = s[4] - s[5];
        t[7] = s[7] + s[6];
        t[6] = s[7] - s[6];
        u = accT'(((longint'(t[6]) + longint'(t[5])) * longint'(coefRot)) >>> rotShift);
        v = accT'(((longint'(t[6]) - longint'(t[5])) * longint'(coefRot)) >>> rotShift);
        case (c)
            2'd0: begin r.d0 = t[0] + t[7]; r.d1 = t[0] - t[7]; end
            2'd1: begin r.d0 = t[1] + u;    r.d1 = t[1] - u;    end
            2'd2: begin r.d0 = t[2] + v;    r.d1 = t[2] - v;    end
            default: begin r.d0 = t[3] + t[4]; r.d1 = t[3] - t[4]; end
        endcase
        return r;
    endfunction

    // Synchronous memory, data one cycle after the strobe
    initial begin : memoryModel
        dataInA = '0;
        dataInB = '0;
        forever begin
            @(negedge clk);
            readPending = dataInRead;
            readAddr    = dataInAddress;
            @(posedge clk);
            #2;
            if (readPending) begin
                dataInA = mem[readAddr].a;
                dataInB = mem[readAddr].b;
            end
        end
    end

    always @(negedge clk) begin
        if (rst && dataOutEnable) begin
            expOut = refOutput(dataOutPage, dataOutCount);
            outputsSeen = outputsSeen + 1;
            assert (data0Out == expOut.d0 && data1Out == expOut.d1)
            else begin
                dataErrors = dataErrors + 1;
                $display("ERR %0t: page %0d pair %0d got %0d/%0d expected %0d/%0d",
                         $time, dataOutPage, dataOutCount, data0Out, data1Out,
                         expOut.d0, expOut.d1);
            end
        end
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    task automatic fillRandom;
        for (int i = 0; i < 32; i++) begin
            mem[i].a = sampleT'($random(seed));
            mem[i].b = sampleT'($random(seed));
        end
    endtask

    task automatic fillDcOnly;
        for (int i = 0; i < 32; i++) begin
            mem[i] = '0;
            if (i[1:0] == 2'd0) mem[i].a = sampleT'($random(seed));   // x0 of each row
        end
    endtask

    task automatic startBlock(input int holdCycles);
        @(posedge clk);
        #2 dataInEnable = 1'b1;
        repeat (holdCycles) @(posedge clk);
        #2 dataInEnable = 1'b0;
    endtask

    task automatic waitOutputs(input int target);
        wait (outputsSeen >= target);
        repeat (3) @(posedge clk);
    endtask

    task automatic finishRun;
        int assertFails;
        assertFails = dut0.props0.schedFails + dut0.props0.addrFails
                    + dut0.props0.latencyFails + dut0.props0.tagFails
                    + dut0.props0.countFails;
        $display("Summary: %0d outputs checked, %0d data errors, %0d assertion failures",
                 outputsSeen, dataErrors, assertFails);
        if (dataErrors == 0 && assertFails == 0 && outputsSeen == 3 * readSlots * pagesPerBlock)
            $display("ALL TESTS PASSED");
        else begin
            if (outputsSeen != 3 * readSlots * pagesPerBlock)
                $display("Wrong number of outputs: %0d", outputsSeen);
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    initial begin : stimulus
        rst          = 1'b0;
        dataInEnable = 1'b0;
        fillRandom();
        repeat (16) @(posedge clk);
        #2 rst = 1'b1;
        repeat (10) @(posedge clk);   // Idle window, no reads expected
        startBlock(1);
        waitOutputs(32);
        fillRandom();
        startBlock(30);               // Start held well into the block
        waitOutputs(64);
        fillDcOnly();
        startBlock(1);
        waitOutputs(96);
        finishRun();
    end

    // Three blocks plus reset, doubled
    initial begin : watchdog
        #(2 * (3 * slotsPerPage * pagesPerBlock + 16) * 40);
        $display("Timeout: the run did not complete within the watchdog time");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
src/idctPkg.sv
src/idctFetchSeq.sv
src/idctCoefMult.sv
src/idctEvenOddStage.sv
src/idctButterflyStage.sv
src/idctOutputStage.sv
src/idctRow.sv
test/idctRow_props.sv
test/idctRowTb.sv

// File: Makefile
BIN  := obj_dir/VidctRowTb
SRCS := $(shell cat vlog.f)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

$(BIN): vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module idctRowTb -Mdir obj_dir -f vlog.f

clean:
	rm -rf obj_dir
